/* archer_projectile.f */
src/proj_pkg.sv
src/step_divider.sv
src/impact_judge.sv
src/flight_engine.sv
src/aim_decoder.sv
src/archer_projectile.sv
verif/archer_projectile_properties.sv
verif/tb_archer_projectile.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_archer_projectile \
    -f archer_projectile.f -o sim_tb || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "Testbench passed" sim.log && echo "run ok" || { echo "run not ok"; exit 1; }

/* src/aim_decoder.sv */
`default_nettype none

module aim_decoder #(
    parameter int SPEED = 16,
    localparam int QW = $clog2(SPEED) + 1
) (
    input  logic              clk,
    input  logic              rst,
    input  proj_pkg::game_t   game_active,
    input  logic              mouse_clicked,
    input  proj_pkg::coord_t  mouse_x,
    input  proj_pkg::coord_t  mouse_y,
    input  proj_pkg::coord_t  archer_x,
    input  proj_pkg::coord_t  archer_y,
    input  logic              in_flight,
    output logic              launch,
    output proj_pkg::coord_t  start_x,
    output proj_pkg::coord_t  start_y,
    output proj_pkg::step_t   step_x,
    output proj_pkg::step_t   step_y,
    output logic              facing_left,
    output proj_pkg::sector_t direction_sector
);

    import proj_pkg::*;

    localparam int DVW = 13 + QW;

    logic           playing;
    logic           accept;
    logic           busy;
    logic           div_start;
    offset_t        dx_c;
    offset_t        dy_c;
    offset_t        dx_q;
    offset_t        dy_q;
    coord_t         ax;
    coord_t         ay;
    coord_t         major;
    logic [DVW-1:0] dividend_x;
    logic [DVW-1:0] dividend_y;
    logic           done_x;
    logic           done_y;
    logic [QW-1:0]  quot_x;
    logic [QW-1:0]  quot_y;
    sector_t        sector_c;

    assign playing = (game_active == GAME_PLAYING);

    // offsets straight from the click inputs feed the accept test
    assign dx_c = offset_of(mouse_x, archer_x);
    assign dy_c = offset_of(mouse_y, archer_y);

    // one arrow at a time, and a click on the archer itself is dropped
    assign accept = mouse_clicked && playing && !in_flight && !busy &&
                    ((dx_c != '0) || (dy_c != '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            div_start <= 1'b0;
        end else begin
            div_start <= 1'b0;
            if (!playing) begin
                // leaving play abandons the decode
                busy <= 1'b0;
            end else if (accept) begin
                busy      <= 1'b1;
                div_start <= 1'b1;
            end else if (launch) begin
                busy <= 1'b0;
            end
        end
    end

    // click sample held until launch
    always_ff @(posedge clk) begin
        if (accept) begin
            dx_q    <= dx_c;
            dy_q    <= dy_c;
            start_x <= archer_x;
            start_y <= archer_y;
        end
    end

    assign ax    = offset_mag(dx_q);
    assign ay    = offset_mag(dy_q);
    assign major = (ax >= ay) ? ax : ay;

    // magnitude times speed over the major magnitude
    assign dividend_x = DVW'(ax) * DVW'(SPEED);
    assign dividend_y = DVW'(ay) * DVW'(SPEED);

    step_divider #(.SPEED(SPEED)) div_x_i (
        .clk      (clk),
        .rst      (rst),
        .div_start(div_start),
        .dividend (dividend_x),
        .divisor  (major),
        .div_done (done_x),
        .quotient (quot_x)
    );

    step_divider #(.SPEED(SPEED)) div_y_i (
        .clk      (clk),
        .rst      (rst),
        .div_start(div_start),
        .dividend (dividend_y),
        .divisor  (major),
        .div_done (done_y),
        .quotient (quot_y)
    );

    // both dividers run in lockstep
    // a done left over from an abandoned run can only land in the start cycle
    assign launch = busy && playing && !div_start && done_x && done_y;

    // restore signs so the major axis comes out as exactly SPEED
    assign step_x = dx_q[12] ? -step_t'(quot_x) : step_t'(quot_x);
    assign step_y = dy_q[12] ? -step_t'(quot_y) : step_t'(quot_y);

    // octant split at a 2:1 slope with screen y growing downward
    always_comb begin
        if ({ay, 1'b0} <= {1'b0, ax}) begin
            sector_c = dx_q[12] ? SECT_LEFT : SECT_RIGHT;
        end else if ({ax, 1'b0} <= {1'b0, ay}) begin
            sector_c = dy_q[12] ? SECT_UP : SECT_DOWN;
        end else begin
            case ({dx_q[12], dy_q[12]})
                2'b01:   sector_c = SECT_UP_RIGHT;
                2'b11:   sector_c = SECT_UP_LEFT;
                2'b10:   sector_c = SECT_DOWN_LEFT;
                default: sector_c = SECT_DOWN_RIGHT;
            endcase
        end
    end

    // sprite selection follows the arrow that actually launches
    always_ff @(posedge clk) begin
        if (rst) begin
            facing_left      <= 1'b0;
            direction_sector <= SECT_RIGHT;
        end else if (launch) begin
            facing_left      <= dx_q[12];
            direction_sector <= sector_c;
        end
    end

endmodule

`default_nettype wire

/* src/archer_projectile.sv */
`default_nettype none

module archer_projectile #(
    parameter int SPEED    = 16,
    parameter int MAX_DIST = 512
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              frame_tick,
    input  proj_pkg::game_t   game_active,
    input  logic              mouse_clicked,
    input  proj_pkg::coord_t  mouse_x,
    input  proj_pkg::coord_t  mouse_y,
    input  proj_pkg::coord_t  archer_x,
    input  proj_pkg::coord_t  archer_y,
    input  proj_pkg::coord_t  boss_x,
    input  proj_pkg::coord_t  boss_y,
    input  logic              boss_alive,
    output proj_pkg::coord_t  pos_x,
    output proj_pkg::coord_t  pos_y,
    output logic              in_flight,
    output logic              attack_hit,
    output logic              facing_left,
    output proj_pkg::sector_t direction_sector
);

    import proj_pkg::*;

    // decode to execute, valid in the launch cycle
    logic   launch;
    coord_t launch_x;
    coord_t launch_y;
    step_t  step_x;
    step_t  step_y;

    // execute to result and back
    coord_t next_x;
    coord_t next_y;
    coord_t start_x;
    coord_t start_y;
    logic   end_flight;
    logic   boss_hit;

    aim_decoder #(.SPEED(SPEED)) decode_i (
        .clk             (clk),
        .rst             (rst),
        .game_active     (game_active),
        .mouse_clicked   (mouse_clicked),
        .mouse_x         (mouse_x),
        .mouse_y         (mouse_y),
        .archer_x        (archer_x),
        .archer_y        (archer_y),
        .in_flight       (in_flight),
        .launch          (launch),
        .start_x         (launch_x),
        .start_y         (launch_y),
        .step_x          (step_x),
        .step_y          (step_y),
        .facing_left     (facing_left),
        .direction_sector(direction_sector)
    );

    flight_engine execute_i (
        .clk          (clk),
        .rst          (rst),
        .game_active  (game_active),
        .frame_tick   (frame_tick),
        .launch       (launch),
        .launch_x     (launch_x),
        .launch_y     (launch_y),
        .launch_step_x(step_x),
        .launch_step_y(step_y),
        .end_flight   (end_flight),
        .boss_hit     (boss_hit),
        .pos_x        (pos_x),
        .pos_y        (pos_y),
        .start_x      (start_x),
        .start_y      (start_y),
        .next_x       (next_x),
        .next_y       (next_y),
        .in_flight    (in_flight),
        .attack_hit   (attack_hit)
    );

    impact_judge #(.MAX_DIST(MAX_DIST)) result_i (
        .next_x    (next_x),
        .next_y    (next_y),
        .start_x   (start_x),
        .start_y   (start_y),
        .boss_x    (boss_x),
        .boss_y    (boss_y),
        .boss_alive(boss_alive),
        .end_flight(end_flight),
        .boss_hit  (boss_hit)
    );

endmodule

`default_nettype wire

/* src/flight_engine.sv */
`default_nettype none

module flight_engine (
    input  logic             clk,
    input  logic             rst,
    input  proj_pkg::game_t  game_active,
    input  logic             frame_tick,
    input  logic             launch,
    input  proj_pkg::coord_t launch_x,
    input  proj_pkg::coord_t launch_y,
    input  proj_pkg::step_t  launch_step_x,
    input  proj_pkg::step_t  launch_step_y,
    input  logic             end_flight,
    input  logic             boss_hit,
    output proj_pkg::coord_t pos_x,
    output proj_pkg::coord_t pos_y,
    output proj_pkg::coord_t start_x,
    output proj_pkg::coord_t start_y,
    output proj_pkg::coord_t next_x,
    output proj_pkg::coord_t next_y,
    output logic             in_flight,
    output logic             attack_hit
);

    import proj_pkg::*;

    logic  playing;
    logic  advance;
    step_t step_x_q;
    step_t step_y_q;

    assign playing = (game_active == GAME_PLAYING);
    assign advance = frame_tick && in_flight;

    // candidate position for the next tick
    // 12-bit wrap turns a move past zero into a large off-screen value
    assign next_x = pos_x + {{4{step_x_q[7]}}, step_x_q};
    assign next_y = pos_y + {{4{step_y_q[7]}}, step_y_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight  <= 1'b0;
            attack_hit <= 1'b0;
            pos_x      <= '0;
            pos_y      <= '0;
        end else begin
            attack_hit <= 1'b0;
            if (!playing) begin
                // arrow vanishes, pos keeps its last value
                in_flight <= 1'b0;
            end else if (launch) begin
                in_flight <= 1'b1;
                pos_x     <= launch_x;
                pos_y     <= launch_y;
            end else if (advance) begin
                pos_x <= next_x;
                pos_y <= next_y;
                // judge verdict applies to the move just taken
                if (end_flight) begin
                    in_flight <= 1'b0;
                end
                attack_hit <= boss_hit;
            end
        end
    end

    // start point and step for the whole flight
    always_ff @(posedge clk) begin
        if (playing && launch) begin
            start_x  <= launch_x;
            start_y  <= launch_y;
            step_x_q <= launch_step_x;
            step_y_q <= launch_step_y;
        end
    end

endmodule

`default_nettype wire

/* src/impact_judge.sv */
`default_nettype none

module impact_judge #(
    parameter int MAX_DIST = 512
) (
    input  proj_pkg::coord_t next_x,
    input  proj_pkg::coord_t next_y,
    input  proj_pkg::coord_t start_x,
    input  proj_pkg::coord_t start_y,
    input  proj_pkg::coord_t boss_x,
    input  proj_pkg::coord_t boss_y,
    input  logic             boss_alive,
    output logic             end_flight,
    output logic             boss_hit
);

    import proj_pkg::*;

    localparam logic [31:0] MAX_SQ = 32'(MAX_DIST) * 32'(MAX_DIST);

    coord_t      bmx;
    coord_t      bmy;
    coord_t      smx;
    coord_t      smy;
    logic [31:0] dist_sq;
    logic        off_screen;
    logic        in_box;
    logic        too_far;

    // wrapped negative positions land here too
    assign off_screen = (next_x >= SCREEN_W) || (next_y >= SCREEN_H);

    // distance to the boss centre per axis
    assign bmx = offset_mag(offset_of(next_x, boss_x));
    assign bmy = offset_mag(offset_of(next_y, boss_y));

    // box edges count as a hit
    assign in_box = boss_alive && (bmx <= BOSS_HALF_W) && (bmy <= BOSS_HALF_H);

    // squared travel from the launch point, no square root needed
    assign smx     = offset_mag(offset_of(next_x, start_x));
    assign smy     = offset_mag(offset_of(next_y, start_y));
    assign dist_sq = 32'(smx) * 32'(smx) + 32'(smy) * 32'(smy);
    assign too_far = (dist_sq > MAX_SQ);

    // priority is screen, then boss, then range
    // only the boss case reports a hit
    always_comb begin
        end_flight = 1'b0;
        boss_hit   = 1'b0;
        if (off_screen) begin
            end_flight = 1'b1;
        end else if (in_box) begin
            end_flight = 1'b1;
            boss_hit   = 1'b1;
        end else if (too_far) begin
            end_flight = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/proj_pkg.sv */
`default_nettype none

package proj_pkg;

    // screen coordinate, unsigned pixels
    typedef logic [11:0] coord_t;
    // pointer minus archer, one bit wider than a coordinate
    typedef logic signed [12:0] offset_t;
    // per-frame arrow step
    typedef logic signed [7:0] step_t;
    // facing octant, counter-clockwise from right
    typedef logic [2:0] sector_t;
    // game state code from the game controller
    typedef logic [1:0] game_t;

    localparam game_t GAME_PLAYING = 2'd1;

    // visible area, a position is on screen when below both limits
    localparam coord_t SCREEN_W = 12'd1024;
    localparam coord_t SCREEN_H = 12'd768;

    // boss hit box half extents around its centre
    localparam coord_t BOSS_HALF_W = 12'd106;
    localparam coord_t BOSS_HALF_H = 12'd95;

    // sprite octant codes
    localparam sector_t SECT_RIGHT      = 3'd0;
    localparam sector_t SECT_UP_RIGHT   = 3'd1;
    localparam sector_t SECT_UP         = 3'd2;
    localparam sector_t SECT_UP_LEFT    = 3'd3;
    localparam sector_t SECT_LEFT       = 3'd4;
    localparam sector_t SECT_DOWN_LEFT  = 3'd5;
    localparam sector_t SECT_DOWN       = 3'd6;
    localparam sector_t SECT_DOWN_RIGHT = 3'd7;

    // signed difference a - b of two screen coordinates
    function automatic offset_t offset_of(coord_t a, coord_t b);
        return offset_t'({1'b0, a} - {1'b0, b});
    endfunction

    // magnitude of an offset, at most 4095 so it fits a coordinate
    function automatic coord_t offset_mag(offset_t v);
        logic [12:0] neg;
        neg = -v;
        return v[12] ? neg[11:0] : v[11:0];
    endfunction

endpackage

`default_nettype wire

/* src/step_divider.sv */
`default_nettype none

module step_divider #(
    parameter int SPEED = 16,
    localparam int QW = $clog2(SPEED) + 1
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          div_start,
    input  logic [12+QW:0] dividend,
    input  logic [11:0]   divisor,
    output logic          div_done,
    output logic [QW-1:0] quotient
);

    localparam int DW = 13 + QW;
    localparam int CW = $clog2(QW + 1);

    // partial remainder
    logic [DW-1:0] rem;
    // divisor aligned to the quotient bit being decided
    logic [DW-1:0] dsh;
    logic [QW-1:0] quot;
    logic [CW-1:0] cnt;
    logic          busy;
    logic          done;
    logic [DW-1:0] r_in;
    logic [DW-1:0] d_in;
    logic [DW-1:0] r_next;
    logic          ge;

    // one restoring step per cycle
    // the start cycle already decides the top bit straight from the ports
    always_comb begin
        if (div_start) begin
            r_in = dividend;
            d_in = DW'(divisor) << (QW - 1);
        end else begin
            r_in = rem;
            d_in = dsh;
        end
        ge     = (r_in >= d_in);
        r_next = ge ? (r_in - d_in) : r_in;
    end

    // step counter, a new start restarts a run in progress
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (div_start) begin
                busy <= 1'b1;
                cnt  <= CW'(QW - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                // last bit lands now, done shows QW cycles after start
                if (cnt == CW'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start || busy) begin
            rem  <= r_next;
            dsh  <= d_in >> 1;
            // msb first, shifted up as lower bits arrive
            quot <= div_start ? QW'(ge) : {quot[QW-2:0], ge};
        end
    end

    assign div_done = done;
    assign quotient = quot;

endmodule

`default_nettype wire

/* verif/archer_projectile_properties.sv */
`default_nettype none

module archer_projectile_properties (
    input logic             clk,
    input logic             rst,
    input proj_pkg::game_t  game_active,
    input logic             frame_tick,
    input logic             launch,
    input logic             in_flight,
    input logic             attack_hit,
    input proj_pkg::coord_t pos_x,
    input proj_pkg::coord_t pos_y
);

    import proj_pkg::*;

    // a boss hit is the move that ends the flight
    hit_ends_flight: assert property (@(posedge clk) disable iff (rst)
        attack_hit |-> $fell(in_flight))
        else $error("attack_hit seen without in_flight falling");

    // strobe, one cycle only
    hit_single_cycle: assert property (@(posedge clk) disable iff (rst)
        attack_hit |=> !attack_hit)
        else $error("attack_hit held for more than one cycle");

    // leaving play removes the arrow at the next edge
    leave_play_stops: assert property (@(posedge clk) disable iff (rst)
        (game_active != GAME_PLAYING) |=> !in_flight)
        else $error("in_flight still high after game_active left playing");

    // position moves only on an advancing tick or a launch
    pos_moves_on_event: assert property (@(posedge clk) disable iff (rst)
        ((pos_x != $past(pos_x)) || (pos_y != $past(pos_y))) |->
            ($past(frame_tick && in_flight) || $past(launch) || $past(rst)))
        else $error("pos changed without a frame tick or launch");

endmodule

bind archer_projectile archer_projectile_properties props_i (
    .clk        (clk),
    .rst        (rst),
    .game_active(game_active),
    .frame_tick (frame_tick),
    .launch     (launch),
    .in_flight  (in_flight),
    .attack_hit (attack_hit),
    .pos_x      (pos_x),
    .pos_y      (pos_y)
);

`default_nettype wire

/* verif/tb_archer_projectile.sv */
`default_nettype none

module tb_archer_projectile;

    import proj_pkg::*;

    localparam int SPEED    = 16;
    localparam int MAX_DIST = 512;
    localparam int QW       = $clog2(SPEED) + 1;
    localparam int FLIGHTS  = 40;

    logic    clk;
    logic    rst;
    logic    frame_tick;
    game_t   game_active;
    logic    mouse_clicked;
    coord_t  mouse_x;
    coord_t  mouse_y;
    coord_t  archer_x;
    coord_t  archer_y;
    coord_t  boss_x;
    coord_t  boss_y;
    logic    boss_alive;
    coord_t  pos_x;
    coord_t  pos_y;
    logic    in_flight;
    logic    attack_hit;
    logic    facing_left;
    sector_t direction_sector;

    // reference model state
    logic [31:0] rng;
    coord_t      m_pos_x;
    coord_t      m_pos_y;
    coord_t      m_start_x;
    coord_t      m_start_y;
    int          m_step_x;
    int          m_step_y;
    int          i;

    archer_projectile #(.SPEED(SPEED), .MAX_DIST(MAX_DIST)) dut_i (
        .clk             (clk),
        .rst             (rst),
        .frame_tick      (frame_tick),
        .game_active     (game_active),
        .mouse_clicked   (mouse_clicked),
        .mouse_x         (mouse_x),
        .mouse_y         (mouse_y),
        .archer_x        (archer_x),
        .archer_y        (archer_y),
        .boss_x          (boss_x),
        .boss_y          (boss_y),
        .boss_alive      (boss_alive),
        .pos_x           (pos_x),
        .pos_y           (pos_y),
        .in_flight       (in_flight),
        .attack_hit      (attack_hit),
        .facing_left     (facing_left),
        .direction_sector(direction_sector)
    );

    always #2 clk = ~clk;

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_coord(string name, coord_t got, coord_t exp);
        if (got !== exp) report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_sector(string name, sector_t got, sector_t exp);
        if (got !== exp) report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int rand_below(int n);
        rng = xorshift32(rng);
        return int'(rng % 32'(n));
    endfunction

    function automatic int abs_int(int v);
        return (v < 0) ? -v : v;
    endfunction

    // octant split at a 2:1 slope, screen y grows downward
    function automatic sector_t expected_sector(int dx, int dy);
        if (2 * abs_int(dy) <= abs_int(dx)) return (dx < 0) ? 3'd4 : 3'd0;
        if (2 * abs_int(dx) <= abs_int(dy)) return (dy < 0) ? 3'd2 : 3'd6;
        if (dx >= 0) return (dy < 0) ? 3'd1 : 3'd7;
        return (dy < 0) ? 3'd3 : 3'd5;
    endfunction

    // truncated magnitude times speed over major, sign restored
    function automatic int expected_step(int d, int major);
        int q;
        q = abs_int(d) * SPEED / major;
        return (d < 0) ? -q : q;
    endfunction

    // screen exit first, then boss box, then range
    function automatic logic flight_ends(coord_t nx, coord_t ny, output logic hit);
        int sdx;
        int sdy;
        hit = 1'b0;
        if ((nx >= 12'd1024) || (ny >= 12'd768)) return 1'b1;
        if (boss_alive && (abs_int(int'(nx) - int'(boss_x)) <= 106) &&
            (abs_int(int'(ny) - int'(boss_y)) <= 95)) begin
            hit = 1'b1;
            return 1'b1;
        end
        sdx = int'(nx) - int'(m_start_x);
        sdy = int'(ny) - int'(m_start_y);
        return (sdx * sdx + sdy * sdy) > (MAX_DIST * MAX_DIST);
    endfunction

    // inputs change 1 unit after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // no arrow, nothing moves
    task automatic hold_idle(int n);
        repeat (n) begin
            next_cycle();
            check_flag("in_flight", in_flight, 1'b0);
            check_flag("attack_hit", attack_hit, 1'b0);
            check_coord("pos_x", pos_x, m_pos_x);
            check_coord("pos_y", pos_y, m_pos_y);
        end
    endtask

    task automatic pick_scene();
        archer_x   = coord_t'(rand_below(1024));
        archer_y   = coord_t'(rand_below(768));
        boss_x     = coord_t'(rand_below(1024));
        boss_y     = coord_t'(rand_below(768));
        boss_alive = (rand_below(4) != 0);
        // aim at the boss about a third of the time
        if (rand_below(3) == 0) begin
            mouse_x = coord_t'(int'(boss_x) + rand_below(81) - 40);
            mouse_y = coord_t'(int'(boss_y) + rand_below(81) - 40);
        end else begin
            mouse_x = coord_t'(rand_below(1024));
            mouse_y = coord_t'(rand_below(768));
        end
        if ((mouse_x == archer_x) && (mouse_y == archer_y)) mouse_x = archer_x ^ 12'd1;
    endtask

    task automatic offplay_click();
        int code;
        code        = rand_below(3);
        game_active = (code == 0) ? 2'd0 : 2'(code + 1);
        mouse_clicked = 1'b1;
        next_cycle();
        mouse_clicked = 1'b0;
        hold_idle(QW + 4);
        game_active = GAME_PLAYING;
        hold_idle(1);
    endtask

    task automatic zero_offset_click();
        coord_t keep_x;
        coord_t keep_y;
        keep_x  = mouse_x;
        keep_y  = mouse_y;
        mouse_x = archer_x;
        mouse_y = archer_y;
        mouse_clicked = 1'b1;
        next_cycle();
        mouse_clicked = 1'b0;
        hold_idle(QW + 4);
        mouse_x = keep_x;
        mouse_y = keep_y;
    endtask

    task automatic launch_arrow();
        int dx;
        int dy;
        int major;
        int n;
        check_flag("in_flight", in_flight, 1'b0);
        dx    = int'(mouse_x) - int'(archer_x);
        dy    = int'(mouse_y) - int'(archer_y);
        major = (abs_int(dx) >= abs_int(dy)) ? abs_int(dx) : abs_int(dy);
        m_step_x  = expected_step(dx, major);
        m_step_y  = expected_step(dy, major);
        m_pos_x   = archer_x;
        m_pos_y   = archer_y;
        m_start_x = archer_x;
        m_start_y = archer_y;
        mouse_clicked = 1'b1;
        next_cycle();
        mouse_clicked = 1'b0;
        n = 1;
        while (in_flight !== 1'b1) begin
            if (n > QW + 8) report_failure("in_flight never rose after an accepted click");
            next_cycle();
            n++;
        end
        if (n != QW + 2) begin
            report_failure($sformatf("Fail launch_latency got %h expected %h", n, QW + 2));
        end
        check_coord("pos_x", pos_x, m_pos_x);
        check_coord("pos_y", pos_y, m_pos_y);
        check_sector("direction_sector", direction_sector, expected_sector(dx, dy));
        check_flag("facing_left", facing_left, dx < 0);
    endtask

    task automatic fly(logic do_abort);
        int     abort_at;
        int     ticks;
        coord_t nx;
        coord_t ny;
        logic   hit;
        logic   ended;
        abort_at = do_abort ? 1 + rand_below(4) : -1;
        ticks    = 0;
        ended    = 1'b0;
        while (!ended) begin
            if (ticks > 100) report_failure("arrow still in flight after 100 frame ticks");
            // tick spacing of 2 to 6 cycles
            repeat (1 + rand_below(5)) begin
                next_cycle();
                check_flag("in_flight", in_flight, 1'b1);
                check_flag("attack_hit", attack_hit, 1'b0);
                check_coord("pos_x", pos_x, m_pos_x);
                check_coord("pos_y", pos_y, m_pos_y);
            end
            if (ticks == abort_at) begin
                game_active = (rand_below(2) == 0) ? 2'd0 : 2'd2;
                next_cycle();
                check_flag("in_flight", in_flight, 1'b0);
                check_flag("attack_hit", attack_hit, 1'b0);
                check_coord("pos_x", pos_x, m_pos_x);
                check_coord("pos_y", pos_y, m_pos_y);
                game_active = GAME_PLAYING;
                hold_idle(1);
                return;
            end
            frame_tick = 1'b1;
            // a click while the arrow flies must be dropped
            if (rand_below(4) == 0) mouse_clicked = 1'b1;
            next_cycle();
            frame_tick    = 1'b0;
            mouse_clicked = 1'b0;
            nx      = coord_t'(int'(m_pos_x) + m_step_x);
            ny      = coord_t'(int'(m_pos_y) + m_step_y);
            ended   = flight_ends(nx, ny, hit);
            m_pos_x = nx;
            m_pos_y = ny;
            check_coord("pos_x", pos_x, m_pos_x);
            check_coord("pos_y", pos_y, m_pos_y);
            check_flag("in_flight", in_flight, !ended);
            check_flag("attack_hit", attack_hit, hit);
            ticks++;
        end
    endtask

    // overall limit on run time
    initial begin
        #400000;
        report_failure("simulation did not finish in time");
    end

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        frame_tick    = 1'b0;
        game_active   = GAME_PLAYING;
        mouse_clicked = 1'b0;
        mouse_x       = '0;
        mouse_y       = '0;
        archer_x      = '0;
        archer_y      = '0;
        boss_x        = '0;
        boss_y        = '0;
        boss_alive    = 1'b0;
        rng           = 32'h21956275;
        m_pos_x       = '0;
        m_pos_y       = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("in_flight", in_flight, 1'b0);
        check_flag("attack_hit", attack_hit, 1'b0);
        check_flag("facing_left", facing_left, 1'b0);
        check_sector("direction_sector", direction_sector, 3'd0);
        hold_idle(2);
        for (i = 0; i < FLIGHTS; i++) begin
            pick_scene();
            if (rand_below(4) == 0) offplay_click();
            if (rand_below(4) == 0) zero_offset_click();
            launch_arrow();
            fly(rand_below(5) == 0);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
